/* rtl/arcade_pkg.sv */
package arcade_pkg;

	localparam int rom_addr_w = 15;
	localparam int dl_addr_w  = 25;

	typedef logic [7:0]            byte_t;
	typedef logic [15:0]           rom_word_t;
	typedef logic [rom_addr_w-1:0] rom_addr_t;
	typedef logic [dl_addr_w-1:0]  dl_addr_t;
	typedef logic [15:0]           sample_t;
	typedef logic [7:0]            joy_t; // 0 right, 1 left, 2 down, 3 up, 4 fire1, 5 fire2

	// ps/2 set 2 scan codes
	localparam byte_t key_up     = 8'h75;
	localparam byte_t key_down   = 8'h72;
	localparam byte_t key_left   = 8'h6B;
	localparam byte_t key_right  = 8'h74;
	localparam byte_t key_coin   = 8'h76; // esc
	localparam byte_t key_start1 = 8'h05; // f1
	localparam byte_t key_start2 = 8'h06; // f2
	localparam byte_t key_fire1  = 8'h29; // space
	localparam byte_t key_fire2  = 8'h11; // left alt

	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire1;
		logic fire2;
		logic coin;
		logic start1;
		logic start2;
	} controls_t;

	typedef struct packed {
		logic [2:0] r;
		logic [2:0] g;
		logic [1:0] b;
	} core_rgb_t;

	typedef struct packed {
		logic [5:0] r;
		logic [5:0] g;
		logic [5:0] b;
		logic       hs;
		logic       vs;
	} vga_t;

endpackage

/* rtl/arcade_shell.sv */
`timescale 1ns/1ps

module arcade_shell (
	input  logic                  sys_clk,
	input  logic                  arst_n,
	input  logic                  dl_active,
	input  logic                  dl_wr,
	input  arcade_pkg::dl_addr_t  dl_addr,
	input  arcade_pkg::byte_t     dl_data,
	input  logic                  status_reset,
	input  logic                  board_reset,
	input  logic                  key_strobe,
	input  logic                  key_pressed,
	input  arcade_pkg::byte_t     key_code,
	input  arcade_pkg::joy_t      joy0,
	input  arcade_pkg::joy_t      joy1,
	input  arcade_pkg::rom_addr_t rom_addr,
	input  arcade_pkg::core_rgb_t core_rgb,
	input  logic                  blank_n,
	input  logic                  hs,
	input  logic                  vs,
	input  logic                  csync,
	input  logic                  tv15khz,
	input  arcade_pkg::sample_t   audio_in,
	output arcade_pkg::byte_t     rom_byte,
	output logic                  core_reset,
	output arcade_pkg::controls_t controls,
	output arcade_pkg::vga_t      vga,
	output logic                  audio_l,
	output logic                  audio_r,
	output logic                  led
);
	import arcade_pkg::*;

	logic      wr_en;
	rom_addr_t wr_word_addr;
	logic [1:0] wr_lanes;
	rom_word_t wr_data;

	assign led     = ~dl_active; // dark while downloading
	assign audio_r = audio_l;

	rom_loader u_loader (
		.sys_clk      (sys_clk),
		.arst_n       (arst_n),
		.dl_active    (dl_active),
		.dl_wr        (dl_wr),
		.dl_addr      (dl_addr),
		.dl_data      (dl_data),
		.status_reset (status_reset),
		.board_reset  (board_reset),
		.wr_en        (wr_en),
		.wr_word_addr (wr_word_addr),
		.wr_lanes     (wr_lanes),
		.wr_data      (wr_data),
		.core_reset   (core_reset)
	);

	rom_store u_store (
		.sys_clk      (sys_clk),
		.wr_en        (wr_en),
		.wr_word_addr (wr_word_addr),
		.wr_lanes     (wr_lanes),
		.wr_data      (wr_data),
		.rom_addr     (rom_addr),
		.rom_byte     (rom_byte)
	);

	input_mapper u_mapper (
		.sys_clk     (sys_clk),
		.arst_n      (arst_n),
		.key_strobe  (key_strobe),
		.key_pressed (key_pressed),
		.key_code    (key_code),
		.joy0        (joy0),
		.joy1        (joy1),
		.controls    (controls)
	);

	video_out u_video (
		.sys_clk  (sys_clk),
		.arst_n   (arst_n),
		.core_rgb (core_rgb),
		.blank_n  (blank_n),
		.hs       (hs),
		.vs       (vs),
		.csync    (csync),
		.tv15khz  (tv15khz),
		.vga      (vga)
	);

	sigma_delta_dac u_dac (
		.sys_clk  (sys_clk),
		.arst_n   (arst_n),
		.audio_in (audio_in),
		.audio_l  (audio_l)
	);

endmodule

/* rtl/input_mapper.sv */
`timescale 1ns/1ps

module input_mapper (
	input  logic                  sys_clk,
	input  logic                  arst_n,
	input  logic                  key_strobe,
	input  logic                  key_pressed,
	input  arcade_pkg::byte_t     key_code,
	input  arcade_pkg::joy_t      joy0,
	input  arcade_pkg::joy_t      joy1,
	output arcade_pkg::controls_t controls
);
	import arcade_pkg::*;

	controls_t keys; // latched keyboard state, same layout as controls

	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			keys <= '0;
		end else if (key_strobe) begin
			case (key_code)
				key_up:     keys.up     <= key_pressed;
				key_down:   keys.down   <= key_pressed;
				key_left:   keys.left   <= key_pressed;
				key_right:  keys.right  <= key_pressed;
				key_fire1:  keys.fire1  <= key_pressed;
				key_fire2:  keys.fire2  <= key_pressed;
				key_coin:   keys.coin   <= key_pressed;
				key_start1: keys.start1 <= key_pressed;
				key_start2: keys.start2 <= key_pressed;
				default: ; // other codes ignored
			endcase
		end
	end

	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			controls <= '0;
		end else begin
			controls.right  <= keys.right | joy0[0] | joy1[0];
			controls.left   <= keys.left  | joy0[1] | joy1[1];
			controls.down   <= keys.down  | joy0[2] | joy1[2];
			controls.up     <= keys.up    | joy0[3] | joy1[3];
			controls.fire1  <= keys.fire1 | joy0[4] | joy1[4];
			controls.fire2  <= keys.fire2 | joy0[5] | joy1[5];
			controls.coin   <= keys.coin; // keyboard only
			controls.start1 <= keys.start1;
			controls.start2 <= keys.start2;
		end
	end

endmodule

/* rtl/rom_loader.sv */
`timescale 1ns/1ps

module rom_loader (
	input  logic                 sys_clk,
	input  logic                 arst_n,
	input  logic                 dl_active,
	input  logic                 dl_wr,
	input  arcade_pkg::dl_addr_t dl_addr,
	input  arcade_pkg::byte_t    dl_data,
	input  logic                 status_reset,
	input  logic                 board_reset,
	output logic                 wr_en,
	output arcade_pkg::rom_addr_t wr_word_addr,
	output logic [1:0]           wr_lanes,
	output arcade_pkg::rom_word_t wr_data,
	output logic                 core_reset
);
	import arcade_pkg::*;

	logic dl_wr_d;
	logic dl_active_d;
	logic rom_loaded;
	logic wr_edge;

	assign wr_edge = dl_active & dl_wr & ~dl_wr_d;

	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			dl_wr_d     <= 1'b0;
			dl_active_d <= 1'b0;
			wr_en       <= 1'b0;
			rom_loaded  <= 1'b0;
			core_reset  <= 1'b1;
		end else begin
			dl_wr_d     <= dl_wr;
			dl_active_d <= dl_active;
			wr_en       <= wr_edge;
			if (dl_active_d && !dl_active)
				rom_loaded <= 1'b1; // sticky until arst_n
			core_reset  <= status_reset | board_reset | ~rom_loaded;
		end
	end

	// address and data captured with the strobe edge
	always_ff @(posedge sys_clk) begin
		if (wr_edge) begin
			wr_word_addr <= {1'b0, dl_addr[rom_addr_w-1:1]};
			wr_lanes     <= {dl_addr[0], ~dl_addr[0]}; // odd byte goes high
			wr_data      <= {dl_data, dl_data};
		end
	end

	a_wr_in_download: assert property (@(posedge sys_clk) disable iff (!arst_n)
		wr_en |-> $past(dl_active));

	a_lanes_onehot: assert property (@(posedge sys_clk) disable iff (!arst_n)
		wr_en |-> $onehot(wr_lanes));

endmodule

/* rtl/rom_store.sv */
`timescale 1ns/1ps

module rom_store (
	input  logic                  sys_clk,
	input  logic                  wr_en,
	input  arcade_pkg::rom_addr_t wr_word_addr,
	input  logic [1:0]            wr_lanes,
	input  arcade_pkg::rom_word_t wr_data,
	input  arcade_pkg::rom_addr_t rom_addr,
	output arcade_pkg::byte_t     rom_byte
);
	import arcade_pkg::*;

	rom_word_t mem [0:2**(rom_addr_w-1)-1];
	rom_word_t rd_word;
	logic      rd_hi; // address bit 0, aligned with the read

	always_ff @(posedge sys_clk) begin
		if (wr_en) begin
			for (int i = 0; i < 2; i++) begin
				if (wr_lanes[i])
					mem[wr_word_addr[rom_addr_w-2:0]][i*8 +: 8] <= wr_data[i*8 +: 8];
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		rd_word <= mem[rom_addr[rom_addr_w-1:1]];
		rd_hi   <= rom_addr[0];
	end

	assign rom_byte = rd_hi ? rd_word[15:8] : rd_word[7:0];

endmodule

/* rtl/sigma_delta_dac.sv */
`timescale 1ns/1ps

module sigma_delta_dac (
	input  logic                sys_clk,
	input  logic                arst_n,
	input  arcade_pkg::sample_t audio_in,
	output logic                audio_l
);
	import arcade_pkg::*;

	logic [16:0] acc;

	// carry out of the 16-bit sum is the output bit, remainder is the error fed back
	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n)
			acc <= '0;
		else
			acc <= {1'b0, acc[15:0]} + {1'b0, sample_t'(audio_in)};
	end

	assign audio_l = acc[16];

endmodule

/* rtl/video_out.sv */
`timescale 1ns/1ps

module video_out (
	input  logic                  sys_clk,
	input  logic                  arst_n,
	input  arcade_pkg::core_rgb_t core_rgb,
	input  logic                  blank_n,
	input  logic                  hs,
	input  logic                  vs,
	input  logic                  csync,
	input  logic                  tv15khz,
	output arcade_pkg::vga_t      vga
);
	import arcade_pkg::*;

	logic [2:0] b3;

	assign b3 = {core_rgb.b, core_rgb.b[1]}; // widen blue to 3 bits first

	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			vga <= '0;
		end else begin
			if (blank_n) begin
				vga.r <= {core_rgb.r, core_rgb.r};
				vga.g <= {core_rgb.g, core_rgb.g};
				vga.b <= {b3, b3};
			end else begin
				vga.r <= '0;
				vga.g <= '0;
				vga.b <= '0;
			end
			// composite sync on hs for 15 kHz monitors
			vga.hs <= tv15khz ? csync : hs;
			vga.vs <= tv15khz | vs;
		end
	end

	a_blank_black: assert property (@(posedge sys_clk) disable iff (!arst_n)
		!blank_n |=> (vga.r == '0 && vga.g == '0 && vga.b == '0));

endmodule

/* verification/tb_arcade_shell.sv */
`timescale 1ns/1ps

module tb_arcade_shell;
	import arcade_pkg::*;

	logic      sys_clk;
	logic      arst_n;
	logic      dl_active;
	logic      dl_wr;
	dl_addr_t  dl_addr;
	byte_t     dl_data;
	logic      status_reset;
	logic      board_reset;
	logic      key_strobe;
	logic      key_pressed;
	byte_t     key_code;
	joy_t      joy0;
	joy_t      joy1;
	rom_addr_t rom_addr;
	core_rgb_t core_rgb;
	logic      blank_n;
	logic      hs;
	logic      vs;
	logic      csync;
	logic      tv15khz;
	sample_t   audio_in;
	byte_t     rom_byte;
	logic      core_reset;
	controls_t controls;
	vga_t      vga;
	logic      audio_l;
	logic      audio_r;
	logic      led;

	logic [31:0] lfsr_state;
	int          errors;
	int          test_errors;
	int          tests_failed;
	byte_t       rom_model [0:32767]; // indexed by byte address
	int          written_q [$];
	controls_t   key_model;
	logic [16:0] acc_model;
	bit          released;

	arcade_shell dut (
		.sys_clk      (sys_clk),
		.arst_n       (arst_n),
		.dl_active    (dl_active),
		.dl_wr        (dl_wr),
		.dl_addr      (dl_addr),
		.dl_data      (dl_data),
		.status_reset (status_reset),
		.board_reset  (board_reset),
		.key_strobe   (key_strobe),
		.key_pressed  (key_pressed),
		.key_code     (key_code),
		.joy0         (joy0),
		.joy1         (joy1),
		.rom_addr     (rom_addr),
		.core_rgb     (core_rgb),
		.blank_n      (blank_n),
		.hs           (hs),
		.vs           (vs),
		.csync        (csync),
		.tv15khz      (tv15khz),
		.audio_in     (audio_in),
		.rom_byte     (rom_byte),
		.core_reset   (core_reset),
		.controls     (controls),
		.vga          (vga),
		.audio_l      (audio_l),
		.audio_r      (audio_r),
		.led          (led)
	);

	initial begin
		sys_clk = 1'b0;
		forever #2 sys_clk = ~sys_clk;
	end

	// taps 32, 22, 2, 1
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] val;
		logic        fb;
		val = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			val = {val[30:0], fb};
		end
		return val;
	endfunction

	task automatic next_cycle;
		@(posedge sys_clk);
		#1;
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		errors++;
		$display("CHECK FAILED %s got %0h expected %0h at %0t", name, got, exp, $time);
	endtask

	task automatic finish_test(input int num, input string name);
		if (errors == test_errors) begin
			$display("test %0d %s: ok", num, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: %0d errors", num, name, errors - test_errors);
		end
		test_errors = errors;
	endtask

	task automatic download_byte(input dl_addr_t addr, input byte_t data, input bit in_reset);
		int hold;
		int gap;
		hold = 1 + rand_bits(2) % 3;
		gap = 3 + rand_bits(2);
		dl_addr = addr;
		dl_data = data;
		dl_wr = 1'b1;
		repeat (hold + gap) begin
			next_cycle();
			hold--;
			dl_data = ~data; // a second write from a held strobe would store this
			if (hold == 0)
				dl_wr = 1'b0;
			if (in_reset && core_reset !== 1'b1)
				report_mismatch("core_reset", core_reset, 1);
		end
		rom_model[addr[14:0]] = data;
		written_q.push_back(addr[14:0]);
	endtask

	task automatic load_under_reset;
		dl_addr_t a;
		byte_t    d;
		if (core_reset !== 1'b1)
			report_mismatch("core_reset", core_reset, 1);
		if (vga !== '0)
			report_mismatch("vga", vga, 0);
		if (controls !== '0)
			report_mismatch("controls", controls, 0);
		dl_active = 1'b1;
		next_cycle();
		if (led !== 1'b0)
			report_mismatch("led", led, 0);
		repeat (8) begin
			a = rand_bits(25);
			d = rand_bits(8);
			download_byte(a, d, 1'b1);
		end
		dl_active = 1'b0;
	endtask

	task automatic wait_core_release(output bit done);
		int cycles;
		done = 1'b0;
		cycles = 0;
		while (!done && cycles < 20) begin
			next_cycle();
			cycles++;
			if (core_reset === 1'b0)
				done = 1'b1;
		end
	endtask

	task automatic pulse_reset_requests;
		if (led !== 1'b1)
			report_mismatch("led", led, 1);
		status_reset = 1'b1;
		next_cycle();
		if (core_reset !== 1'b1)
			report_mismatch("core_reset", core_reset, 1);
		status_reset = 1'b0;
		next_cycle();
		if (core_reset !== 1'b0)
			report_mismatch("core_reset", core_reset, 0);
		board_reset = 1'b1;
		next_cycle();
		if (core_reset !== 1'b1)
			report_mismatch("core_reset", core_reset, 1);
		board_reset = 1'b0;
		next_cycle();
		if (core_reset !== 1'b0)
			report_mismatch("core_reset", core_reset, 0);
	endtask

	task automatic fill_and_read_rom;
		dl_addr_t a;
		dl_addr_t prev;
		byte_t    d;
		int       idx;
		int       ra;
		prev = '0;
		dl_active = 1'b1;
		next_cycle();
		repeat (200) begin
			a = rand_bits(25);
			if (rand_bits(1))
				a = prev ^ 1; // other lane of the same word
			d = rand_bits(8);
			download_byte(a, d, 1'b0);
			prev = a;
		end
		dl_active = 1'b0;
		next_cycle();
		repeat (300) begin
			idx = rand_bits(16) % written_q.size();
			ra = written_q[idx];
			rom_addr = ra;
			next_cycle();
			if (rom_byte !== rom_model[ra])
				report_mismatch("rom_byte", rom_byte, rom_model[ra]);
		end
	endtask

	task automatic drive_controls;
		controls_t exp;
		logic [3:0] sel;
		repeat (400) begin
			sel = rand_bits(4);
			case (sel)
				4'd0: key_code = 8'h75;
				4'd1: key_code = 8'h72;
				4'd2: key_code = 8'h6B;
				4'd3: key_code = 8'h74;
				4'd4: key_code = 8'h76;
				4'd5: key_code = 8'h05;
				4'd6: key_code = 8'h06;
				4'd7: key_code = 8'h29;
				4'd8: key_code = 8'h11;
				default: key_code = rand_bits(8); // mostly unknown codes
			endcase
			key_pressed = rand_bits(1);
			key_strobe = (rand_bits(2) != 0);
			joy0 = rand_bits(8) & rand_bits(8) & rand_bits(8);
			joy1 = rand_bits(8) & rand_bits(8) & rand_bits(8);
			if (key_strobe) begin
				case (key_code)
					8'h75: key_model.up = key_pressed;
					8'h72: key_model.down = key_pressed;
					8'h6B: key_model.left = key_pressed;
					8'h74: key_model.right = key_pressed;
					8'h76: key_model.coin = key_pressed;
					8'h05: key_model.start1 = key_pressed;
					8'h06: key_model.start2 = key_pressed;
					8'h29: key_model.fire1 = key_pressed;
					8'h11: key_model.fire2 = key_pressed;
					default: ;
				endcase
			end
			next_cycle();
			key_strobe = 1'b0;
			next_cycle();
			exp.right = key_model.right | joy0[0] | joy1[0];
			exp.left = key_model.left | joy0[1] | joy1[1];
			exp.down = key_model.down | joy0[2] | joy1[2];
			exp.up = key_model.up | joy0[3] | joy1[3];
			exp.fire1 = key_model.fire1 | joy0[4] | joy1[4];
			exp.fire2 = key_model.fire2 | joy0[5] | joy1[5];
			exp.coin = key_model.coin;
			exp.start1 = key_model.start1;
			exp.start2 = key_model.start2;
			if (controls !== exp)
				report_mismatch("controls", controls, exp);
		end
	endtask

	task automatic compare_video;
		vga_t exp;
		repeat (400) begin
			core_rgb = rand_bits(8);
			blank_n = rand_bits(1);
			hs = rand_bits(1);
			vs = rand_bits(1);
			csync = rand_bits(1);
			tv15khz = rand_bits(1);
			next_cycle();
			exp = '0;
			if (blank_n) begin
				exp.r = {core_rgb.r, core_rgb.r};
				exp.g = {core_rgb.g, core_rgb.g};
				exp.b = {core_rgb.b, core_rgb.b[1], core_rgb.b, core_rgb.b[1]};
			end
			if (tv15khz) begin
				exp.hs = csync;
				exp.vs = 1'b1;
			end else begin
				exp.hs = hs;
				exp.vs = vs;
			end
			if (vga !== exp)
				report_mismatch("vga", vga, exp);
		end
	endtask

	task automatic stream_audio;
		int      stretch;
		int      ones;
		int      diff;
		sample_t level;
		ones = 0;
		for (int s = 0; s < 41; s++) begin
			level = rand_bits(16);
			audio_in = level;
			stretch = (s == 40) ? 4096 : 1 + rand_bits(5); // last stretch measures density
			repeat (stretch) begin
				next_cycle();
				acc_model = {1'b0, acc_model[15:0]} + {1'b0, level};
				if (audio_l !== acc_model[16])
					report_mismatch("audio_l", audio_l, acc_model[16]);
				if (audio_r !== acc_model[16])
					report_mismatch("audio_r", audio_r, acc_model[16]);
				if (s == 40 && audio_l === 1'b1)
					ones++;
			end
		end
		diff = ones * 16 - int'(level);
		if (diff > 16 || diff < -16) begin
			errors++;
			$display("audio_l density is off: %0d ones in 4096 cycles for sample %0h",
				ones, level);
		end
	endtask

	initial begin
		lfsr_state = 32'd97098;
		errors = 0;
		test_errors = 0;
		tests_failed = 0;
		key_model = '0;
		acc_model = '0;
		arst_n = 1'b0;
		dl_active = 1'b0;
		dl_wr = 1'b0;
		dl_addr = '0;
		dl_data = '0;
		status_reset = 1'b0;
		board_reset = 1'b0;
		key_strobe = 1'b0;
		key_pressed = 1'b0;
		key_code = '0;
		joy0 = '0;
		joy1 = '0;
		rom_addr = '0;
		core_rgb = '0;
		blank_n = 1'b0;
		hs = 1'b0;
		vs = 1'b0;
		csync = 1'b0;
		tv15khz = 1'b0;
		audio_in = '0;
		repeat (16) @(posedge sys_clk);
		#1;
		arst_n = 1'b1;
		next_cycle();
		load_under_reset();
		wait_core_release(released);
		if (!released) begin
			$display("timeout: core_reset still high 20 cycles after the download ended");
			$display("STATUS: FAIL");
			$finish;
		end else begin
			pulse_reset_requests();
			finish_test(1, "reset and load gating");
			fill_and_read_rom();
			finish_test(2, "rom download and readback");
			drive_controls();
			finish_test(3, "control mapping");
			compare_video();
			finish_test(4, "video conditioning");
			stream_audio();
			finish_test(5, "audio modulator");
			$display("tests run 5, tests failed %0d, errors %0d", tests_failed, errors);
			if (errors == 0)
				$display("STATUS: PASS");
			else
				$display("STATUS: FAIL");
			$finish;
		end
	end

endmodule

/* vlog.f */
rtl/arcade_pkg.sv
rtl/rom_loader.sv
rtl/rom_store.sv
rtl/input_mapper.sv
rtl/video_out.sv
rtl/sigma_delta_dac.sv
rtl/arcade_shell.sv
verification/tb_arcade_shell.sv
